/* matmul_accel.f */
source/accel_pkg.sv
source/operand_buffer.sv
source/dma_engine.sv
source/mm_engine.sv
source/accel_top.sv
tests/axi_mem_model.sv
tests/accel_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the matmul accelerator testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing -Wno-fatal -f matmul_accel.f --top-module accel_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/Vaccel_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* source/accel_pkg.sv */
/*
  Shared sizes, AXI channel structs and FSM types for the 4x4 matmul accelerator.
  Matrices are fixed at 4x4 signed 32-bit, one 16-beat burst per matrix.
  AXI error responses are carried but never acted on.
*/
package accel_pkg;

    // array and element sizes
    localparam int SA_WIDTH      = 4;
    localparam int DW            = 32;
    localparam int ACC_W         = 2 * DW + 1;
    localparam int BUF_AW        = 2;
    localparam int BUF_DW        = 128;
    localparam int BURST_BEATS   = 16;
    localparam int MM_DRAIN_CYC  = 2 * SA_WIDTH - 1;

    // fixed AXI attributes, 4-byte beats
    localparam logic [7:0] AXI_LEN  = 8'(BURST_BEATS - 1);
    localparam logic [2:0] AXI_SIZE = 3'd2;
    localparam logic       ID_A     = 1'b0;
    localparam logic       ID_B     = 1'b1;

    typedef logic signed [DW-1:0]    elem_t;
    typedef logic signed [ACC_W-1:0] acc_t;
    typedef logic [31:0]             addr_t;
    typedef logic [BUF_DW-1:0]       buf_row_t;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'd0,
        BURST_INCR  = 2'd1,
        BURST_WRAP  = 2'd2
    } axi_burst_e;

    typedef struct packed {
        logic       arvalid;
        logic       arid;
        addr_t      araddr;
        logic [7:0] arlen;
        logic [2:0] arsize;
        axi_burst_e arburst;
    } axi_ar_t;

    typedef struct packed {
        logic       rvalid;
        logic       rid;
        logic [31:0] rdata;
        logic [1:0] rresp;
        logic       rlast;
    } axi_r_t;

    typedef struct packed {
        logic       awvalid;
        logic       awid;
        addr_t      awaddr;
        logic [7:0] awlen;
        logic [2:0] awsize;
        axi_burst_e awburst;
    } axi_aw_t;

    typedef struct packed {
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wlast;
    } axi_w_t;

    typedef struct packed {
        logic       bvalid;
        logic       bid;
        logic [1:0] bresp;
    } axi_b_t;

    // write request into an operand buffer
    typedef struct packed {
        logic                wren;
        logic [BUF_AW-1:0]   waddr;
        logic [BUF_DW/8-1:0] wbyteen;
        buf_row_t            wdata;
    } buf_wr_t;

    typedef enum logic [2:0] {
        IDLE, ADDR_A, ADDR_B, LOAD, WAIT_MM, ADDR_C, WRITE_C, WAIT_B
    } dma_state_e;

    // prefixed to keep apart from the DMA labels
    typedef enum logic [1:0] {
        MM_IDLE, MM_FEED, MM_DRAIN
    } mm_state_e;

endpackage

/* source/accel_top.sv */
/*
  Accelerator top: DMA engine, operand buffers A and B, and the MM engine.
  One job at a time; configuration comes in on plain ports.
*/
`timescale 1ns/1ps

module accel_top
    import accel_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  addr_t   mat_a_addr_i,
    input  addr_t   mat_b_addr_i,
    input  addr_t   mat_c_addr_i,
    input  logic    start_i,
    output logic    done_o,
    output axi_ar_t ar_o,
    input  logic    arready_i,
    input  axi_r_t  r_i,
    output logic    rready_o,
    output axi_aw_t aw_o,
    input  logic    awready_i,
    output axi_w_t  w_o,
    input  logic    wready_i,
    input  axi_b_t  b_i,
    output logic    bready_o
);

    buf_wr_t           buf_a_wr;
    buf_wr_t           buf_b_wr;
    buf_row_t          buf_a_rdata;
    buf_row_t          buf_b_rdata;
    logic [BUF_AW-1:0] buf_raddr;
    logic              mm_start;
    logic              mm_done;
    acc_t              accum [SA_WIDTH][SA_WIDTH];

    dma_engine u_dma (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_a_addr_i (mat_a_addr_i),
        .mat_b_addr_i (mat_b_addr_i),
        .mat_c_addr_i (mat_c_addr_i),
        .start_i      (start_i),
        .done_o       (done_o),
        .ar_o         (ar_o),
        .arready_i    (arready_i),
        .r_i          (r_i),
        .rready_o     (rready_o),
        .aw_o         (aw_o),
        .awready_i    (awready_i),
        .w_o          (w_o),
        .wready_i     (wready_i),
        .b_i          (b_i),
        .bready_o     (bready_o),
        .buf_a_wr_o   (buf_a_wr),
        .buf_b_wr_o   (buf_b_wr),
        .mm_start_o   (mm_start),
        .mm_done_i    (mm_done),
        .accum_i      (accum)
    );

    operand_buffer u_buf_a (
        .clk     (clk),
        .wr_i    (buf_a_wr),
        .raddr_i (buf_raddr),
        .rdata_o (buf_a_rdata)
    );

    operand_buffer u_buf_b (
        .clk     (clk),
        .wr_i    (buf_b_wr),
        .raddr_i (buf_raddr),
        .rdata_o (buf_b_rdata)
    );

    mm_engine u_mm (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (mm_start),
        .buf_a_rdata_i (buf_a_rdata),
        .buf_b_rdata_i (buf_b_rdata),
        .buf_raddr_o   (buf_raddr),
        .done_o        (mm_done),
        .accum_o       (accum)
    );

endmodule

/* source/dma_engine.sv */
/*
  Fetches A and B as two 16-beat AXI read bursts, packs beats into buffer rows,
  starts the MM engine and writes C back as one 16-beat burst.
  Addresses are sampled at start. Response codes are ignored.
*/
`timescale 1ns/1ps

module dma_engine
    import accel_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  addr_t   mat_a_addr_i,
    input  addr_t   mat_b_addr_i,
    input  addr_t   mat_c_addr_i,
    input  logic    start_i,
    output logic    done_o,
    output axi_ar_t ar_o,
    input  logic    arready_i,
    input  axi_r_t  r_i,
    output logic    rready_o,
    output axi_aw_t aw_o,
    input  logic    awready_i,
    output axi_w_t  w_o,
    input  logic    wready_i,
    input  axi_b_t  b_i,
    output logic    bready_o,
    output buf_wr_t buf_a_wr_o,
    output buf_wr_t buf_b_wr_o,
    output logic    mm_start_o,
    input  logic    mm_done_i,
    input  acc_t    accum_i [SA_WIDTH][SA_WIDTH]
);

    dma_state_e state_q;
    addr_t      addr_a_q;
    addr_t      addr_b_q;
    addr_t      addr_c_q;
    logic [3:0] wbeat_q;
    logic       start_job;
    logic       r_hs;
    logic       rows_full;

    // per-operand packer, indexed by rid
    buf_row_t   pack_q [2];
    logic [1:0] beat_q [2];
    logic [2:0] row_q  [2];
    buf_wr_t    wr_q   [2];

    assign start_job = (state_q == IDLE) && start_i;
    assign r_hs      = r_i.rvalid && rready_o;
    assign rows_full = (row_q[ID_A] == 3'(SA_WIDTH)) && (row_q[ID_B] == 3'(SA_WIDTH));

    always_ff @(posedge clk) begin
        if (start_job) begin
            addr_a_q <= mat_a_addr_i;
            addr_b_q <= mat_b_addr_i;
            addr_c_q <= mat_c_addr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= IDLE;
            wbeat_q    <= '0;
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= ADDR_A;
                    end
                end
                ADDR_A: begin
                    if (arready_i) begin
                        state_q <= ADDR_B;
                    end
                end
                ADDR_B: begin
                    if (arready_i) begin
                        state_q <= LOAD;
                    end
                end
                LOAD: begin
                    // last row write is on the bus this cycle
                    if (rows_full) begin
                        mm_start_o <= 1'b1;
                        state_q    <= WAIT_MM;
                    end
                end
                WAIT_MM: begin
                    if (mm_done_i) begin
                        state_q <= ADDR_C;
                    end
                end
                ADDR_C: begin
                    if (awready_i) begin
                        wbeat_q <= '0;
                        state_q <= WRITE_C;
                    end
                end
                WRITE_C: begin
                    if (wready_i) begin
                        wbeat_q <= wbeat_q + 4'd1;
                        if (wbeat_q == 4'(BURST_BEATS - 1)) begin
                            state_q <= WAIT_B;
                        end
                    end
                end
                WAIT_B: begin
                    if (b_i.bvalid) begin
                        done_o  <= 1'b1;
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // first beat of a row ends up in the top lane
    always_ff @(posedge clk) begin
        for (int op = 0; op < 2; op++) begin
            wr_q[op].wren <= 1'b0;
            if (!rst_n || start_job) begin
                beat_q[op] <= '0;
                row_q[op]  <= '0;
            end else if (r_hs && (r_i.rid == op[0])) begin
                pack_q[op] <= {pack_q[op][BUF_DW-DW-1:0], r_i.rdata};
                beat_q[op] <= beat_q[op] + 2'd1;
                if (beat_q[op] == 2'd3) begin
                    wr_q[op].wren    <= 1'b1;
                    wr_q[op].waddr   <= row_q[op][BUF_AW-1:0];
                    wr_q[op].wbyteen <= '1;
                    wr_q[op].wdata   <= {pack_q[op][BUF_DW-DW-1:0], r_i.rdata};
                    row_q[op]        <= row_q[op] + 3'd1;
                end
            end
        end
    end

    assign buf_a_wr_o = wr_q[ID_A];
    assign buf_b_wr_o = wr_q[ID_B];

    // channel payloads are constant per state, valid depends on state only
    always_comb begin
        ar_o         = '0;
        ar_o.arvalid = (state_q == ADDR_A) || (state_q == ADDR_B);
        ar_o.arid    = (state_q == ADDR_B) ? ID_B : ID_A;
        ar_o.araddr  = (state_q == ADDR_B) ? addr_b_q : addr_a_q;
        ar_o.arlen   = AXI_LEN;
        ar_o.arsize  = AXI_SIZE;
        ar_o.arburst = BURST_INCR;

        aw_o         = '0;
        aw_o.awvalid = (state_q == ADDR_C);
        aw_o.awaddr  = addr_c_q;
        aw_o.awlen   = AXI_LEN;
        aw_o.awsize  = AXI_SIZE;
        aw_o.awburst = BURST_INCR;

        // beat n carries C[n/4][n%4], low 32 bits
        w_o        = '0;
        w_o.wvalid = (state_q == WRITE_C);
        w_o.wdata  = accum_i[wbeat_q[3:2]][wbeat_q[1:0]][DW-1:0];
        w_o.wstrb  = '1;
        w_o.wlast  = (wbeat_q == 4'(BURST_BEATS - 1));

        rready_o = (state_q == LOAD);
        bready_o = (state_q == WAIT_B);
    end

endmodule

/* source/mm_engine.sv */
/*
  4x4 output-stationary systolic array with its buffer read sequencer.
  done follows start by exactly 12 cycles. Accumulators hold until the next start.
*/
`timescale 1ns/1ps

module mm_engine
    import accel_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_i,
    input  buf_row_t          buf_a_rdata_i,
    input  buf_row_t          buf_b_rdata_i,
    output logic [BUF_AW-1:0] buf_raddr_o,
    output logic              done_o,
    output acc_t              accum_o [SA_WIDTH][SA_WIDTH]
);

    mm_state_e  state_q;
    logic [2:0] drain_q;
    logic       rd_valid_q;
    logic       acc_en;

    // operands at the array edges, after skew
    elem_t a_edge [SA_WIDTH];
    elem_t b_edge [SA_WIDTH];

    // values passed right (A) and down (B) between cells
    elem_t a_q [SA_WIDTH][SA_WIDTH-1];
    elem_t b_q [SA_WIDTH-1][SA_WIDTH];

    assign acc_en = (state_q != MM_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= MM_IDLE;
            buf_raddr_o <= '0;
            drain_q     <= '0;
            rd_valid_q  <= 1'b0;
            done_o      <= 1'b0;
        end else begin
            done_o     <= 1'b0;
            rd_valid_q <= (state_q == MM_FEED);
            case (state_q)
                MM_IDLE: begin
                    if (start_i) begin
                        buf_raddr_o <= '0;
                        state_q     <= MM_FEED;
                    end
                end
                MM_FEED: begin
                    buf_raddr_o <= buf_raddr_o + 1'b1;
                    if (buf_raddr_o == BUF_AW'(SA_WIDTH - 1)) begin
                        drain_q <= '0;
                        state_q <= MM_DRAIN;
                    end
                end
                MM_DRAIN: begin
                    // wait for the last operand to reach the far corner
                    drain_q <= drain_q + 3'd1;
                    if (drain_q == 3'(MM_DRAIN_CYC - 1)) begin
                        done_o  <= 1'b1;
                        state_q <= MM_IDLE;
                    end
                end
                default: state_q <= MM_IDLE;
            endcase
        end
    end

    // lane i holds A[i][k] and B[k][i]; delay both by i cycles
    for (genvar i = 0; i < SA_WIDTH; i++) begin : g_skew
        elem_t a_pipe [i+1];
        elem_t b_pipe [i+1];

        // zeros outside the valid window keep the accumulators steady
        assign a_pipe[0] = rd_valid_q ? elem_t'(buf_a_rdata_i[BUF_DW-1-i*DW -: DW]) : '0;
        assign b_pipe[0] = rd_valid_q ? elem_t'(buf_b_rdata_i[BUF_DW-1-i*DW -: DW]) : '0;

        for (genvar d = 1; d <= i; d++) begin : g_dly
            always_ff @(posedge clk) begin
                a_pipe[d] <= a_pipe[d-1];
                b_pipe[d] <= b_pipe[d-1];
            end
        end

        assign a_edge[i] = a_pipe[i];
        assign b_edge[i] = b_pipe[i];
    end

    for (genvar i = 0; i < SA_WIDTH; i++) begin : g_row
        for (genvar j = 0; j < SA_WIDTH; j++) begin : g_col
            elem_t a_in;
            elem_t b_in;
            acc_t  acc_q;

            if (j == 0) begin : g_a_edge
                assign a_in = a_edge[i];
            end else begin : g_a_pass
                assign a_in = a_q[i][j-1];
            end

            if (i == 0) begin : g_b_edge
                assign b_in = b_edge[j];
            end else begin : g_b_pass
                assign b_in = b_q[i-1][j];
            end

            if (j < SA_WIDTH - 1) begin : g_a_reg
                always_ff @(posedge clk) begin
                    a_q[i][j] <= a_in;
                end
            end

            if (i < SA_WIDTH - 1) begin : g_b_reg
                always_ff @(posedge clk) begin
                    b_q[i][j] <= b_in;
                end
            end

            always_ff @(posedge clk) begin
                if (start_i) begin
                    acc_q <= '0;
                end else if (acc_en) begin
                    acc_q <= acc_q + acc_t'(a_in) * acc_t'(b_in);
                end
            end

            assign accum_o[i][j] = acc_q;
        end
    end

endmodule

/* source/operand_buffer.sv */
/*
  Four-row operand memory with byte enables and a registered read port.
  Contents are undefined until written.
*/
`timescale 1ns/1ps

module operand_buffer
    import accel_pkg::*;
(
    input  logic              clk,
    input  buf_wr_t           wr_i,
    input  logic [BUF_AW-1:0] raddr_i,
    output buf_row_t          rdata_o
);

    buf_row_t mem [2**BUF_AW];

    always_ff @(posedge clk) begin
        if (wr_i.wren) begin
            for (int b = 0; b < BUF_DW / 8; b++) begin
                if (wr_i.wbyteen[b]) begin
                    mem[wr_i.waddr][b*8 +: 8] <= wr_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

/* tests/accel_tb.sv */
/*
  Testbench for accel_top: runs the jobs listed in tests/accel_tests.txt.
  Memory holds 128 words, so all addresses must lie below 0x200.
  Jobs from the fourth on see heavy back-pressure.
*/
`timescale 1ns/1ps

module accel_tb
    import accel_pkg::*;
();

    localparam int MEM_WORDS = 128;
    localparam int MAX_TESTS = 16;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        start;
    addr_t       a_addr;
    addr_t       b_addr;
    addr_t       c_addr;
    logic        done;
    axi_ar_t     ar;
    axi_r_t      r;
    axi_aw_t     aw;
    axi_w_t      w;
    axi_b_t      b;
    logic        arready;
    logic        rready;
    logic        awready;
    logic        wready;
    logic        bready;
    int          stall_pct;
    logic        load_en;
    logic [6:0]  load_idx;
    logic [31:0] load_data;

    addr_t       t_a [MAX_TESTS];
    addr_t       t_b [MAX_TESTS];
    addr_t       t_c [MAX_TESTS];
    logic [31:0] va  [MAX_TESTS][16];
    logic [31:0] vb  [MAX_TESTS][16];
    logic [31:0] vc  [MAX_TESTS][16];
    logic [31:0] shadow [MEM_WORDS];
    int          n_tests;

    // handshake log of the current job
    int          done_cnt;
    int          ar_cnt;
    int          aw_cnt;
    int          w_cnt;
    int          b_cnt;
    int          wlast_cnt;
    int          wlast_pos;
    addr_t       ar_addr [4];
    int          ar_id   [4];
    int          ar_len  [4];
    addr_t       aw_addr;
    int          aw_len;

    int          val_errs = 0;
    int          proto_errs = 0;
    int          cycles = 0;
    int          limit = 100000;

    accel_top i_dut (
        .clk(clk), .rst_n(rst_n),
        .mat_a_addr_i(a_addr), .mat_b_addr_i(b_addr), .mat_c_addr_i(c_addr),
        .start_i(start), .done_o(done),
        .ar_o(ar), .arready_i(arready), .r_i(r), .rready_o(rready),
        .aw_o(aw), .awready_i(awready), .w_o(w), .wready_i(wready),
        .b_i(b), .bready_o(bready)
    );

    axi_mem_model i_mem (
        .clk(clk), .rst_n(rst_n), .stall_pct_i(stall_pct),
        .load_en_i(load_en), .load_idx_i(load_idx), .load_data_i(load_data),
        .ar_i(ar), .arready_o(arready), .r_o(r), .rready_i(rready),
        .aw_i(aw), .awready_o(awready), .w_i(w), .wready_o(wready),
        .b_o(b), .bready_i(bready)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run stopped after %0d cycles, a job never finished", cycles);
            $display("value errors: %0d, protocol errors: %0d", val_errs, proto_errs + 1);
            $display("Errors found");
            $finish;
        end
    end

    // sampled mid-cycle, the values seen by the next rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (ar.arvalid && arready) begin
                // 4-byte beats in INCR bursts
                check_count(int'(ar.arsize), 2, "arsize");
                check_count(int'(ar.arburst), 1, "arburst");
                if (ar_cnt < 4) begin
                    ar_addr[ar_cnt] = ar.araddr;
                    ar_id[ar_cnt]   = int'(ar.arid);
                    ar_len[ar_cnt]  = int'(ar.arlen);
                end
                ar_cnt++;
            end
            if (aw.awvalid && awready) begin
                check_count(int'(aw.awsize), 2, "awsize");
                check_count(int'(aw.awburst), 1, "awburst");
                aw_addr = aw.awaddr;
                aw_len  = int'(aw.awlen);
                aw_cnt++;
            end
            if (w.wvalid && wready) begin
                check_count(int'(w.wstrb), 15, "wstrb");
                if (w.wlast) begin
                    wlast_pos = w_cnt;
                    wlast_cnt++;
                end
                w_cnt++;
            end
            if (b.bvalid && bready) begin
                b_cnt++;
            end
            if (done) begin
                done_cnt++;
            end
        end
    end

    task automatic check_elem(input elem_t got, input elem_t exp, input string what);
        if (got !== exp) begin
            val_errs++;
            $display("ERR %0t: %s is %0d (%h), expected %0d (%h)", $time, what, got, got, exp, exp);
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            val_errs++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            val_errs++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic read_vectors();
        int    fd;
        int    rc;
        string line;
        n_tests = 0;
        fd = $fopen("tests/accel_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test vector file tests/accel_tests.txt");
            proto_errs++;
        end else begin
            // two comment lines describe the columns
            rc = $fgets(line, fd);
            rc = $fgets(line, fd);
            while (n_tests < MAX_TESTS) begin
                rc = $fscanf(fd, "%h %h %h", t_a[n_tests], t_b[n_tests], t_c[n_tests]);
                if (rc != 3) begin
                    break;
                end
                for (int k = 0; k < 16; k++) rc = $fscanf(fd, "%h", va[n_tests][k]);
                for (int k = 0; k < 16; k++) rc = $fscanf(fd, "%h", vb[n_tests][k]);
                for (int k = 0; k < 16; k++) rc = $fscanf(fd, "%h", vc[n_tests][k]);
                n_tests++;
            end
            $fclose(fd);
            if (n_tests == 0) begin
                $display("the test vector file holds no complete test");
                proto_errs++;
            end
        end
    endtask

    task automatic check_idle_outputs();
        repeat (10) begin
            @(negedge clk);
            check_count(int'(ar.arvalid), 0, "arvalid after reset");
            check_count(int'(aw.awvalid), 0, "awvalid after reset");
            check_count(int'(w.wvalid), 0, "wvalid after reset");
            check_count(int'(rready), 0, "rready after reset");
            check_count(int'(bready), 0, "bready after reset");
            check_count(int'(done), 0, "done after reset");
        end
    endtask

    task automatic run_job(input int t);
        int    a_base;
        int    b_base;
        int    c_base;
        string tag;
        a_base = int'(t_a[t][8:2]);
        b_base = int'(t_b[t][8:2]);
        c_base = int'(t_c[t][8:2]);
        // fill pattern from the byte address and the test number
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = {16'(i * 4), ~16'(i * 4)} ^ 32'(t);
        end
        for (int k = 0; k < 16; k++) begin
            shadow[(a_base + k) % MEM_WORDS] = va[t][k];
            shadow[(b_base + k) % MEM_WORDS] = vb[t][k];
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_idx  <= 7'(i);
            load_data <= shadow[i];
        end
        @(posedge clk);
        load_en   <= 1'b0;
        stall_pct <= (t >= 3) ? 60 : 10;
        a_addr    <= t_a[t];
        b_addr    <= t_b[t];
        c_addr    <= t_c[t];
        done_cnt  = 0;
        ar_cnt    = 0;
        aw_cnt    = 0;
        w_cnt     = 0;
        b_cnt     = 0;
        wlast_cnt = 0;
        wlast_pos = -1;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        // a second start while busy must be ignored
        repeat (4) @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (done_cnt == 0) @(negedge clk);
        repeat (30) @(negedge clk);

        tag = $sformatf("test %0d", t);
        check_count(done_cnt, 1, {tag, " done pulses"});
        check_count(ar_cnt, 2, {tag, " AR handshakes"});
        check_addr(ar_addr[0], t_a[t], {tag, " first araddr"});
        check_count(ar_id[0], int'(ID_A), {tag, " first arid"});
        check_count(ar_len[0], 15, {tag, " first arlen"});
        check_addr(ar_addr[1], t_b[t], {tag, " second araddr"});
        check_count(ar_id[1], int'(ID_B), {tag, " second arid"});
        check_count(ar_len[1], 15, {tag, " second arlen"});
        check_count(aw_cnt, 1, {tag, " AW handshakes"});
        check_addr(aw_addr, t_c[t], {tag, " awaddr"});
        check_count(aw_len, 15, {tag, " awlen"});
        check_count(w_cnt, 16, {tag, " W beats"});
        check_count(wlast_cnt, 1, {tag, " wlast beats"});
        check_count(wlast_pos, 15, {tag, " wlast position"});
        check_count(b_cnt, 1, {tag, " B handshakes"});
        for (int k = 0; k < 16; k++) begin
            check_elem(elem_t'(i_mem.mem[(c_base + k) % MEM_WORDS]), elem_t'(vc[t][k]),
                       $sformatf("%s C[%0d][%0d]", tag, k / 4, k % 4));
        end
        // words around the C region keep their contents
        if (c_base > 0) begin
            check_elem(elem_t'(i_mem.mem[c_base - 1]), elem_t'(shadow[c_base - 1]),
                       {tag, " word below C"});
        end
        if (c_base + 16 < MEM_WORDS) begin
            check_elem(elem_t'(i_mem.mem[c_base + 16]), elem_t'(shadow[c_base + 16]),
                       {tag, " word above C"});
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        a_addr    = '0;
        b_addr    = '0;
        c_addr    = '0;
        stall_pct = 10;
        load_en   = 1'b0;
        load_idx  = '0;
        load_data = '0;
        read_vectors();
        limit = n_tests * (400 + MEM_WORDS) + 100;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        check_idle_outputs();
        for (int t = 0; t < n_tests; t++) begin
            run_job(t);
        end
        $display("value errors: %0d, protocol errors: %0d", val_errs, proto_errs);
        if (val_errs + proto_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* tests/accel_tests.txt */
# per test: a_addr b_addr c_addr, then 16 words of A (column-major), 16 of B (row-major),
# 16 expected words of C (row-major, low 32 bits), all hex; tests are separated by blank lines
000 040 080
1 0 0 0 0 1 0 0 0 0 1 0 0 0 0 1
1 2 3 4 5 6 7 8 9 a b c d e f 10
1 2 3 4 5 6 7 8 9 a b c d e f 10

100 140 0c0
2 0 0 0 0 2 0 0 0 0 2 0 0 0 0 2
ffffffff fffffffe fffffffd fffffffc fffffffb fffffffa fffffff9 fffffff8 fffffff7 fffffff6 fffffff5 fffffff4 fffffff3 fffffff2 fffffff1 fffffff0
fffffffe fffffffc fffffffa fffffff8 fffffff6 fffffff4 fffffff2 fffffff0 ffffffee ffffffec ffffffea ffffffe8 ffffffe6 ffffffe4 ffffffe2 ffffffe0

080 000 140
10001 10001 10001 10001 10001 10001 10001 10001 10001 10001 10001 10001 10001 10001 10001 10001
10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000
40000 40000 40000 40000 40000 40000 40000 40000 40000 40000 40000 40000 40000 40000 40000 40000

0c0 100 040
7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff 7fffffff
2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2
fffffff8 fffffff8 fffffff8 fffffff8 fffffff8 fffffff8 fffffff8 fffffff8 fffffff8 fffffff8 fffffff8 fffffff8 fffffff8 fffffff8 fffffff8 fffffff8

040 180 100
1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0
1 2 3 4 5 6 7 8 9 a b c d e f 10
1 2 3 4 1 2 3 4 1 2 3 4 1 2 3 4

1c0 0c0 000
1 0 0 0 0 2 0 0 0 0 3 0 0 0 0 4
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff
ffffffff ffffffff ffffffff ffffffff fffffffe fffffffe fffffffe fffffffe fffffffd fffffffd fffffffd fffffffd fffffffc fffffffc fffffffc fffffffc

/* tests/axi_mem_model.sv */
/*
  AXI slave memory of 128 words for the testbench, byte addresses wrap at 512.
  Up to one read burst per ID, beats of the two IDs interleave at random.
  Write strobes are ignored; stall_pct_i sets the chance of a ready or valid gap.
*/
`timescale 1ns/1ps

module axi_mem_model
    import accel_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  int          stall_pct_i,
    input  logic        load_en_i,
    input  logic [6:0]  load_idx_i,
    input  logic [31:0] load_data_i,
    input  axi_ar_t     ar_i,
    output logic        arready_o,
    output axi_r_t      r_o,
    input  logic        rready_i,
    input  axi_aw_t     aw_i,
    output logic        awready_o,
    input  axi_w_t      w_i,
    output logic        wready_o,
    output axi_b_t      b_o,
    input  logic        bready_i
);

    localparam int MEM_WORDS = 128;

    logic [31:0] mem [MEM_WORDS];
    int          seed = 58720;
    logic        ar_rdy_q;
    logic        aw_rdy_q;
    logic        w_rdy_q;
    logic        wr_busy_q;
    logic        b_pend_q;
    logic [6:0]  waddr_q;

    // beats still to be sent and next word, per read ID
    logic [4:0]  left_q  [2];
    logic [6:0]  raddr_q [2];

    assign arready_o = ar_rdy_q && (left_q[ar_i.arid] == 5'd0);
    assign awready_o = aw_rdy_q && !wr_busy_q && !b_pend_q && !b_o.bvalid;
    assign wready_o  = w_rdy_q && wr_busy_q;

    always @(posedge clk) begin
        logic has0;
        logic has1;
        logic id;
        if (!rst_n) begin
            ar_rdy_q  <= 1'b0;
            aw_rdy_q  <= 1'b0;
            w_rdy_q   <= 1'b0;
            wr_busy_q <= 1'b0;
            b_pend_q  <= 1'b0;
            r_o       <= '0;
            b_o       <= '0;
            left_q[0] <= '0;
            left_q[1] <= '0;
        end else begin
            ar_rdy_q <= (($random(seed) & 32'h7fff_ffff) % 100) >= stall_pct_i;
            aw_rdy_q <= (($random(seed) & 32'h7fff_ffff) % 100) >= stall_pct_i;
            w_rdy_q  <= (($random(seed) & 32'h7fff_ffff) % 100) >= stall_pct_i;

            if (load_en_i) begin
                mem[load_idx_i] <= load_data_i;
            end

            if (ar_i.arvalid && arready_o) begin
                left_q[ar_i.arid]  <= 5'(ar_i.arlen + 8'd1);
                raddr_q[ar_i.arid] <= ar_i.araddr[8:2];
            end

            // next read beat, from either pending burst
            if (!r_o.rvalid || rready_i) begin
                r_o.rvalid <= 1'b0;
                has0 = (left_q[0] != 5'd0);
                has1 = (left_q[1] != 5'd0);
                if ((has0 || has1) &&
                    ((($random(seed) & 32'h7fff_ffff) % 100) >= stall_pct_i)) begin
                    if (has0 && has1) begin
                        id = $random(seed) & 1;
                    end else begin
                        id = has1;
                    end
                    r_o.rvalid  <= 1'b1;
                    r_o.rid     <= id;
                    r_o.rdata   <= mem[raddr_q[id]];
                    r_o.rresp   <= 2'b00;
                    r_o.rlast   <= (left_q[id] == 5'd1);
                    left_q[id]  <= left_q[id] - 5'd1;
                    raddr_q[id] <= raddr_q[id] + 7'd1;
                end
            end

            if (aw_i.awvalid && awready_o) begin
                wr_busy_q <= 1'b1;
                waddr_q   <= aw_i.awaddr[8:2];
            end

            if (w_i.wvalid && wready_o) begin
                mem[waddr_q] <= w_i.wdata;
                waddr_q      <= waddr_q + 7'd1;
                if (w_i.wlast) begin
                    wr_busy_q <= 1'b0;
                    b_pend_q  <= 1'b1;
                end
            end

            if (b_o.bvalid && bready_i) begin
                b_o.bvalid <= 1'b0;
            end else if (b_pend_q && !b_o.bvalid &&
                         ((($random(seed) & 32'h7fff_ffff) % 100) >= stall_pct_i)) begin
                b_o.bvalid <= 1'b1;
                b_o.bid    <= 1'b0;
                b_o.bresp  <= 2'b00;
                b_pend_q   <= 1'b0;
            end
        end
    end

endmodule
